// ==== verilog/caches_macros.svh ====
`ifndef CACHES_MACROS_SVH
`define CACHES_MACROS_SVH

// ************************************************************
// Memory system sizes
// ************************************************************

// Width of one RAM word and of each half of a scratchpad row.
`define WORD_W 32

// Word address bits of the 1024-word RAM array.
`define RAM_ADDR_BITS 10

// Busy cycles before the access cycle of every RAM transfer.
`define RAM_LATENCY 2

// ************************************************************
// Scratchpad transfer geometry
// ************************************************************

`define SP_ROWS 4          // Rows fetched by one scratchpad load.
`define SP_ROW_STRIDE 8    // Bytes from one row to the next.
`define SP_WORD_STRIDE 4   // Bytes from low word to high word.

`endif

// ==== verilog/caches_pkg.sv ====
`include "caches_macros.svh"

package caches_pkg;

  // ************************************************************
  // Data and address types
  // ************************************************************

  typedef logic [`WORD_W-1:0] word_t;      // One RAM word.
  typedef logic [2*`WORD_W-1:0] dword_t;   // One scratchpad row.
  typedef logic [31:0] addr_t;             // Byte address.

  // Index of a row within one scratchpad load.
  typedef logic [$clog2(`SP_ROWS)-1:0] row_t;

  // Counts the busy cycles of one RAM access.
  typedef logic [$clog2(`RAM_LATENCY+1)-1:0] lat_t;

  // ************************************************************
  // State encodings
  // ************************************************************

  typedef enum logic [1:0] {
    FREE,
    BUSY,
    ACCESS
  } ramstate_t;

  typedef enum logic [2:0] {
    IDLE,
    SP_LOAD1,   // Low word of the current row.
    SP_LOAD2,   // High word of the current row.
    SP_STORE1,
    SP_STORE2
  } arbiter_state_t;

endpackage

// ==== verilog/arbiter_caches_if.sv ====
`timescale 1ns/1ps

interface arbiter_caches_if import caches_pkg::*; ();

  // Data cache request.
  logic dREN;
  logic dWEN;
  addr_t daddr;
  word_t dstore;
  logic dwait;
  word_t dload;
  logic load_done;
  logic store_done;

  // Instruction cache request.
  logic iREN;
  addr_t iaddr;
  logic iwait;
  word_t iload;

  // RAM bus.
  logic ramREN;
  logic ramWEN;
  addr_t ramaddr;
  word_t ramstore;
  word_t ramload;
  ramstate_t ramstate;

  modport cc (
    input dREN, dWEN, daddr, dstore,
    input iREN, iaddr,
    input ramload, ramstate,
    output dwait, dload, load_done, store_done,
    output iwait, iload,
    output ramREN, ramWEN, ramaddr, ramstore
  );

  modport ram (
    input ramREN, ramWEN, ramaddr, ramstore,
    output ramload, ramstate
  );

endinterface

// ==== verilog/scratchpad_if.sv ====
`timescale 1ns/1ps

interface scratchpad_if import caches_pkg::*; ();

  // Load side of the scratchpad engine.
  logic sLoad;
  addr_t load_addr;
  dword_t load_data;
  row_t sLoad_row;
  logic sLoad_hit;

  // Store side of the scratchpad engine.
  logic sStore;
  addr_t store_addr;
  dword_t store_data;
  logic sStore_hit;

  modport arbiter (
    input sLoad, load_addr,
    input sStore, store_addr, store_data,
    output load_data, sLoad_row, sLoad_hit,
    output sStore_hit
  );

endinterface

// ==== verilog/ram_model.sv ====
`timescale 1ns/1ps
`include "caches_macros.svh"

module ram_model import caches_pkg::*; (
  input logic CLK,
  input logic nRST,
  arbiter_caches_if.ram acif
);

  localparam int DEPTH = 2 ** `RAM_ADDR_BITS;

  word_t mem [0:DEPTH-1];
  lat_t lat_count;
  logic req;
  logic [`RAM_ADDR_BITS-1:0] word_idx;

  assign req = acif.ramREN || acif.ramWEN;
  assign word_idx = acif.ramaddr[`RAM_ADDR_BITS+1:2];   // Byte address to word index.

  // ************************************************************
  // Latency counter
  // ************************************************************

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_count <= '0;
    end
    else if (!req) begin
      lat_count <= '0;
    end
    else if (lat_count == lat_t'(`RAM_LATENCY)) begin
      lat_count <= '0;   // A held request starts a fresh access.
    end
    else begin
      lat_count <= lat_count + lat_t'(1);
    end
  end

  always_comb begin
    if (!req) begin
      acif.ramstate = FREE;
    end
    else if (lat_count < lat_t'(`RAM_LATENCY)) begin
      acif.ramstate = BUSY;
    end
    else begin
      acif.ramstate = ACCESS;
    end
  end

  // ************************************************************
  // Storage array
  // ************************************************************

  always_ff @(posedge CLK) begin
    if (acif.ramWEN && (acif.ramstate == ACCESS)) begin
      mem[word_idx] <= acif.ramstore;   // Committed at the end of the access cycle.
    end
  end

  // Read data is only meaningful while the access is reported.
  always_comb begin
    if (acif.ramstate == ACCESS) begin
      acif.ramload = mem[word_idx];
    end
    else begin
      acif.ramload = '0;
    end
  end

endmodule

// ==== verilog/memory_arbiter.sv ====
`timescale 1ns/1ps
`include "caches_macros.svh"

module memory_arbiter import caches_pkg::*; (
  input logic CLK,
  input logic nRST,
  arbiter_caches_if.cc acif,
  scratchpad_if.arbiter spif
);

  arbiter_state_t state, next_state;
  row_t row, next_row;

  dword_t load_data_q;
  row_t load_row_q;
  logic load_hit_q;

  logic ram_ready;
  logic sp_req;
  logic low_done;
  logic row_done;
  addr_t row_base;

  assign ram_ready = (acif.ramstate == ACCESS);
  assign sp_req = spif.sLoad || spif.sStore;

  // Word addresses of the row being fetched.
  assign row_base = spif.load_addr + addr_t'(row) * addr_t'(`SP_ROW_STRIDE);

  assign low_done = (state == SP_LOAD1) && spif.sLoad && ram_ready;
  assign row_done = (state == SP_LOAD2) && spif.sLoad && ram_ready;

  // ************************************************************
  // State register and row counter
  // ************************************************************

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      row <= '0;
    end
    else begin
      state <= next_state;
      row <= next_row;
    end
  end

  always_comb begin
    next_state = state;
    next_row = row;
    case (state)
      IDLE: begin
        if (spif.sLoad) begin
          next_state = SP_LOAD1;
          next_row = '0;
        end
        else if (spif.sStore) begin
          next_state = SP_STORE1;
        end
      end
      SP_LOAD1: begin
        if (!spif.sLoad) begin
          next_state = IDLE;   // Load abandoned.
        end
        else if (ram_ready) begin
          next_state = SP_LOAD2;
        end
      end
      SP_LOAD2: begin
        if (!spif.sLoad) begin
          next_state = IDLE;
        end
        else if (ram_ready) begin
          if (row == row_t'(`SP_ROWS-1)) begin
            next_state = IDLE;
            next_row = '0;
          end
          else begin
            next_state = SP_LOAD1;
            next_row = row + row_t'(1);
          end
        end
      end
      SP_STORE1: begin
        if (!spif.sStore) begin
          next_state = IDLE;
        end
        else if (ram_ready) begin
          next_state = SP_STORE2;
        end
      end
      SP_STORE2: begin
        if (!spif.sStore || ram_ready) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  // ************************************************************
  // Scratchpad row assembly
  // ************************************************************

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      load_data_q <= '0;
      load_row_q <= '0;
      load_hit_q <= 1'b0;
    end
    else begin
      load_hit_q <= row_done;   // One pulse per finished row.
      if (low_done) begin
        load_data_q[`WORD_W-1:0] <= acif.ramload;
      end
      if (row_done) begin
        load_data_q[2*`WORD_W-1:`WORD_W] <= acif.ramload;
        load_row_q <= row;
      end
    end
  end

  assign spif.load_data = load_data_q;
  assign spif.sLoad_row = load_row_q;
  assign spif.sLoad_hit = load_hit_q;

  // ************************************************************
  // RAM bus steering
  // ************************************************************

  always_comb begin
    acif.ramREN = 1'b0;
    acif.ramWEN = 1'b0;
    acif.ramaddr = '0;
    acif.ramstore = '0;
    acif.dwait = 1'b1;
    acif.dload = '0;
    acif.iwait = 1'b1;
    acif.iload = '0;
    acif.load_done = 1'b0;
    acif.store_done = 1'b0;
    spif.sStore_hit = 1'b0;
    case (state)
      IDLE: begin
        // A pending scratchpad request leaves the bus quiet for one cycle.
        if (!sp_req) begin
          if (acif.dREN || acif.dWEN) begin
            acif.ramWEN = acif.dWEN;
            acif.ramREN = acif.dREN && !acif.dWEN;
            acif.ramaddr = acif.daddr;
            acif.ramstore = acif.dstore;
            if (ram_ready) begin
              acif.dwait = 1'b0;
              acif.store_done = acif.dWEN;
              acif.load_done = !acif.dWEN;
              acif.dload = acif.dWEN ? '0 : acif.ramload;
            end
          end
          else if (acif.iREN) begin
            acif.ramREN = 1'b1;
            acif.ramaddr = acif.iaddr;
            if (ram_ready) begin
              acif.iwait = 1'b0;
              acif.iload = acif.ramload;
            end
          end
        end
      end
      SP_LOAD1: begin
        acif.ramREN = spif.sLoad;
        acif.ramaddr = row_base;
      end
      SP_LOAD2: begin
        acif.ramREN = spif.sLoad;
        acif.ramaddr = row_base + addr_t'(`SP_WORD_STRIDE);
      end
      SP_STORE1: begin
        acif.ramWEN = spif.sStore;
        acif.ramaddr = spif.store_addr;
        acif.ramstore = spif.store_data[`WORD_W-1:0];
      end
      SP_STORE2: begin
        acif.ramWEN = spif.sStore;
        acif.ramaddr = spif.store_addr + addr_t'(`SP_WORD_STRIDE);
        acif.ramstore = spif.store_data[2*`WORD_W-1:`WORD_W];
        spif.sStore_hit = spif.sStore && ram_ready;
      end
      default: begin
        acif.ramREN = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/memory_system.sv ====
`timescale 1ns/1ps

module memory_system import caches_pkg::*; (
  input logic CLK,
  input logic nRST,
  // Data cache.
  input logic dREN,
  input logic dWEN,
  input addr_t daddr,
  input word_t dstore,
  output word_t dload,
  output logic dwait,
  // Instruction cache.
  input logic iREN,
  input addr_t iaddr,
  output word_t iload,
  output logic iwait,
  output logic load_done,
  output logic store_done,
  // Scratchpad engine.
  input logic sLoad,
  input logic sStore,
  input addr_t load_addr,
  input addr_t store_addr,
  input dword_t store_data,
  output dword_t load_data,
  output row_t sLoad_row,
  output logic sLoad_hit,
  output logic sStore_hit
);

  arbiter_caches_if acif ();
  scratchpad_if spif ();

  // ************************************************************
  // Port binding
  // ************************************************************

  assign acif.dREN = dREN;
  assign acif.dWEN = dWEN;
  assign acif.daddr = daddr;
  assign acif.dstore = dstore;
  assign acif.iREN = iREN;
  assign acif.iaddr = iaddr;
  assign dload = acif.dload;
  assign dwait = acif.dwait;
  assign iload = acif.iload;
  assign iwait = acif.iwait;
  assign load_done = acif.load_done;
  assign store_done = acif.store_done;

  assign spif.sLoad = sLoad;
  assign spif.sStore = sStore;
  assign spif.load_addr = load_addr;
  assign spif.store_addr = store_addr;
  assign spif.store_data = store_data;
  assign load_data = spif.load_data;
  assign sLoad_row = spif.sLoad_row;
  assign sLoad_hit = spif.sLoad_hit;
  assign sStore_hit = spif.sStore_hit;

  memory_arbiter arbiter_inst (
    .CLK(CLK),
    .nRST(nRST),
    .acif(acif.cc),
    .spif(spif.arbiter)
  );

  ram_model ram_inst (
    .CLK(CLK),
    .nRST(nRST),
    .acif(acif.ram)
  );

endmodule

// ==== test/memory_system_tests.svh ====
// ************************************************************
// Random numbers, reference memory and checks
// ************************************************************

function automatic logic lfsr_bit();
  logic out_bit;
  out_bit = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out_bit) begin
    lfsr_state = lfsr_state ^ LFSR_TAPS;
  end
  return out_bit;
endfunction

function automatic logic [31:0] random_bits(input int n);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value = {value[30:0], lfsr_bit()};
  end
  return value;
endfunction

function automatic addr_t random_addr();
  return random_bits(`RAM_ADDR_BITS) << 2;   // A word-aligned address inside the array.
endfunction

function automatic word_t recorded(input addr_t addr);
  return ref_mem[addr[`RAM_ADDR_BITS+1:2]];
endfunction

task automatic record(input addr_t addr, input word_t data);
  ref_mem[addr[`RAM_ADDR_BITS+1:2]] = data;
endtask

task automatic compare_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
  assert (actual === expected) else begin
    $display("Mismatch in %s: %s expected %0h actual %0h",
             current_test, what, expected, actual);
    error_count++;
  end
endtask

task automatic expect_true(input logic cond, input string what);
  assert (cond === 1'b1) else begin
    $display("Error in %s: %s", current_test, what);
    error_count++;
  end
endtask

task automatic start_test(input string name);
  current_test = name;
  test_errors = error_count;
endtask

task automatic finish_test();
  test_count++;
  if (error_count == test_errors) begin
    $display("%s: ok", current_test);
  end
  else begin
    failed_tests++;
    $display("%s: %0d errors", current_test, error_count - test_errors);
  end
endtask

// Performs one data-cache word access and checks it against the reference memory.
task automatic data_access(input logic write, input addr_t addr, input word_t wdata);
  int cycles;
  @(negedge CLK);
  dREN = !write;
  dWEN = write;
  daddr = addr;
  dstore = wdata;
  @(negedge CLK);
  cycles = 2;
  while (dwait && cycles < 4 * ACCESS_CYCLES) begin
    @(negedge CLK);
    cycles++;
  end
  expect_true(!dwait, "the data cache got no response");
  compare_value("access cycles", ACCESS_CYCLES, cycles);
  compare_value(write ? "store_done" : "load_done", 1, write ? store_done : load_done);
  if (write) begin
    record(addr, wdata);
  end
  else begin
    compare_value("dload", recorded(addr), dload);
  end
  @(negedge CLK);
  expect_true(dwait && !load_done && !store_done, "dwait low for more than one cycle");
  dREN = 1'b0;
  dWEN = 1'b0;
endtask

// ************************************************************
// Directed tests
// ************************************************************

task automatic reset_state_test();
  start_test("reset_state");
  @(negedge CLK);
  expect_true(dwait && iwait, "a wait output is low after reset");
  expect_true(!sLoad_hit && !sStore_hit, "a scratchpad hit is set after reset");
  expect_true(!load_done && !store_done, "a done pulse is set after reset");
  compare_value("load_data", 0, load_data);
  compare_value("sLoad_row", 0, sLoad_row);
  finish_test();
endtask

task automatic write_read_test();
  addr_t addr;
  start_test("write_read");
  for (int i = 0; i < 8; i++) begin
    addr = random_addr();
    written.push_back(addr);
    data_access(1'b1, addr, random_bits(32));
  end
  foreach (written[i]) begin
    data_access(1'b0, written[i], '0);
  end
  finish_test();
endtask

task automatic priority_test();
  int cycles;
  start_test("priority");
  @(negedge CLK);
  dREN = 1'b1;
  iREN = 1'b1;
  daddr = written[0];
  iaddr = written[1];
  @(negedge CLK);
  cycles = 2;
  while (dwait && cycles < 4 * ACCESS_CYCLES) begin
    expect_true(iwait, "iwait low while the data cache waits");
    @(negedge CLK);
    cycles++;
  end
  compare_value("data cycles", ACCESS_CYCLES, cycles);
  compare_value("dload", recorded(written[0]), dload);
  expect_true(iwait, "the instruction read was served with the data read");
  @(negedge CLK);
  dREN = 1'b0;
  @(negedge CLK);
  cycles = 2;
  while (iwait && cycles < 4 * ACCESS_CYCLES) begin
    @(negedge CLK);
    cycles++;
  end
  compare_value("instruction cycles", ACCESS_CYCLES, cycles);
  compare_value("iload", recorded(written[1]), iload);
  @(negedge CLK);
  iREN = 1'b0;
  finish_test();
endtask

task automatic sp_store_test();
  int cycles;
  word_t low_word;
  word_t high_word;
  start_test("sp_store");
  low_word = random_bits(32);
  high_word = random_bits(32);
  @(negedge CLK);
  sStore = 1'b1;
  store_addr = random_addr();
  store_data = {high_word, low_word};
  @(negedge CLK);
  cycles = 2;
  while (!sStore_hit && cycles < 8 * ACCESS_CYCLES) begin
    @(negedge CLK);
    cycles++;
  end
  compare_value("cycles to sStore_hit", 1 + 2 * ACCESS_CYCLES, cycles);   // One idle cycle.
  record(store_addr, low_word);
  record(store_addr + `SP_WORD_STRIDE, high_word);
  @(negedge CLK);
  expect_true(!sStore_hit, "sStore_hit high for more than one cycle");
  sStore = 1'b0;
  data_access(1'b0, store_addr, '0);
  data_access(1'b0, store_addr + `SP_WORD_STRIDE, '0);
  finish_test();
endtask

task automatic sp_load_test();
  int cycles;
  int hits;
  addr_t row_addr;
  start_test("sp_load");
  load_addr = random_addr();
  for (int i = 0; i < 2 * `SP_ROWS; i++) begin
    data_access(1'b1, load_addr + i * `SP_WORD_STRIDE, random_bits(32));
  end
  @(negedge CLK);
  sLoad = 1'b1;
  hits = 0;
  cycles = 1;
  while (sLoad && cycles < 3 * `SP_ROWS * 2 * ACCESS_CYCLES) begin
    @(negedge CLK);
    cycles++;
    if (sLoad_hit) begin
      row_addr = load_addr + hits * `SP_ROW_STRIDE;
      compare_value("hit cycle", 2 + (hits + 1) * 2 * ACCESS_CYCLES, cycles);
      compare_value("sLoad_row", hits, sLoad_row);
      compare_value("load_data",
                    {recorded(row_addr + `SP_WORD_STRIDE), recorded(row_addr)}, load_data);
      hits++;
      if (hits == `SP_ROWS) begin
        sLoad = 1'b0;   // Lowered on the last hit.
      end
    end
  end
  compare_value("sLoad_hit pulses", `SP_ROWS, hits);
  sLoad = 1'b0;
  repeat (2 * ACCESS_CYCLES) begin
    @(negedge CLK);
    expect_true(!sLoad_hit, "sLoad_hit after the last row");
  end
  finish_test();
endtask

task automatic sp_abort_test();
  start_test("sp_abort");
  @(negedge CLK);
  sLoad = 1'b1;
  load_addr = random_addr();
  repeat (2) @(negedge CLK);
  sLoad = 1'b0;   // Still on the low word of row 0.
  repeat (4 * ACCESS_CYCLES) begin
    @(negedge CLK);
    expect_true(!sLoad_hit, "sLoad_hit after an aborted load");
  end
  data_access(1'b0, written[2], '0);
  finish_test();
endtask

// ==== test/memory_system_tb.sv ====
`timescale 1ns/1ps
`include "caches_macros.svh"

module memory_system_tb import caches_pkg::*; ();

  localparam int ACCESS_CYCLES = `RAM_LATENCY + 1;
  localparam int TIMEOUT_CYCLES = 2000;   // The whole sequence needs a few hundred cycles.
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic CLK = 1'b0;
  logic nRST;
  logic dREN, dWEN, iREN, sLoad, sStore;
  addr_t daddr, iaddr, load_addr, store_addr;
  word_t dstore, dload, iload;
  dword_t store_data, load_data;
  row_t sLoad_row;
  logic dwait, iwait, load_done, store_done, sLoad_hit, sStore_hit;

  logic [31:0] lfsr_state = 32'hcd4f;
  word_t ref_mem [0:(2**`RAM_ADDR_BITS)-1];   // Every completed write.
  addr_t written[$];
  string current_test;
  int error_count = 0;
  int test_errors = 0;
  int failed_tests = 0;
  int test_count = 0;
  int cycle_count = 0;

  memory_system memory_system_inst (.*);

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  `include "memory_system_tests.svh"

  initial begin
    dREN = 1'b0;
    dWEN = 1'b0;
    iREN = 1'b0;
    sLoad = 1'b0;
    sStore = 1'b0;
    daddr = '0;
    iaddr = '0;
    load_addr = '0;
    store_addr = '0;
    dstore = '0;
    store_data = '0;
    nRST = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    reset_state_test();
    write_read_test();
    priority_test();
    sp_store_test();
    sp_load_test();
    sp_abort_test();

    @(negedge CLK);
    $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end
    else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+verilog
+incdir+test
verilog/caches_pkg.sv
verilog/arbiter_caches_if.sv
verilog/scratchpad_if.sv
verilog/ram_model.sv
verilog/memory_arbiter.sv
verilog/memory_system.sv
test/memory_system_tb.sv
